//--- src/aes_cfg.svh
// AES-128 core constants, included by the packages and by any module that needs a fixed value
`ifndef AES_CFG_SVH
`define AES_CFG_SVH

//////////////////////////////
// Block geometry
//////////////////////////////

// Width of the text block and of the cipher key
`define AES_BLOCK_BITS 128

// Rounds for a 128-bit key
`define AES_ROUNDS 10

//////////////////////////////
// Field constants
//////////////////////////////

// Low byte of x^8 + x^4 + x^3 + x + 1, folded in by xtime
`define AES_GF_POLY 8'h1b

// Constant added by the S-box affine map
`define AES_SBOX_AFFINE 8'h63

// Round constant used by the first key expansion step
`define AES_RCON_FIRST 8'h01

`endif

//--- src/aes_state_pkg.sv
// Cipher state types and the byte doubling shared by MixColumns, S-box and round constants
`include "aes_cfg.svh"

package aes_state_pkg;

	//////////////////////////////
	// State layout
	//////////////////////////////

	// One byte of the state
	typedef logic [7:0] aes_byte_t;

	// One column of the state, also one key word
	// Row 0 sits in the top byte
	typedef struct packed {
		aes_byte_t r0;
		aes_byte_t r1;
		aes_byte_t r2;
		aes_byte_t r3;
	} aes_col_t;

	// Full state, round key or text block
	// Column 0 sits in the top word, matching text_in byte order
	typedef struct packed {
		aes_col_t c0;
		aes_col_t c1;
		aes_col_t c2;
		aes_col_t c3;
	} aes_state_t;

	//////////////////////////////
	// Field helpers
	//////////////////////////////

	// Multiply by x in GF(2^8)
	// Reduction applied when the top bit shifts out
	function automatic aes_byte_t xtime(input aes_byte_t b);
		return {b[6:0], 1'b0} ^ (`AES_GF_POLY & {8{b[7]}});
	endfunction

endpackage

//--- src/aes_key_pkg.sv
// Key schedule types, imported by the key expansion, the round control and the top level
`include "aes_cfg.svh"

package aes_key_pkg;

	//////////////////////////////
	// Key schedule
	//////////////////////////////

	// Cipher key as applied by the caller
	// Word 0 in the top 32 bits
	typedef logic [`AES_BLOCK_BITS-1:0] aes_key_t;

	// Round constant byte
	// Only the top byte of the Rcon word is ever nonzero
	typedef logic [7:0] aes_rcon_t;

	//////////////////////////////
	// Round sequencing
	//////////////////////////////

	// Counter width holds AES_ROUNDS plus 1
	localparam int AES_CNT_BITS = $clog2(`AES_ROUNDS + 2);

	// Round counter
	typedef logic [AES_CNT_BITS-1:0] aes_round_cnt_t;

endpackage

//--- src/aes_sub_bytes.sv
// Byte-wise AES S-box over any packed payload, used for SubBytes on the state and SubWord on keys
`include "aes_cfg.svh"

module aes_sub_bytes
	import aes_state_pkg::*;
#(
	parameter type payload_t = aes_state_t
)
(
	input  payload_t din,
	output payload_t dout
);

	// Payload seen as a plain byte array
	localparam int NBYTES = $bits(payload_t) / 8;

	logic [NBYTES*8-1:0] din_v;
	logic [NBYTES*8-1:0] dout_v;

	//////////////////////////////
	// GF(2^8) arithmetic
	//////////////////////////////

	// Shift and add multiply
	function automatic aes_byte_t gf_mul(input aes_byte_t a, input aes_byte_t b);
		aes_byte_t p;
		aes_byte_t aa;
		p = 8'h00;
		aa = a;
		for (int i = 0; i < 8; i++)
		begin
			if (b[i])
				p = p ^ aa;
			aa = xtime(aa);
		end
		return p;
	endfunction

	// Inverse as a^254, product of a^2 .. a^128
	// Zero stays zero
	function automatic aes_byte_t gf_inv(input aes_byte_t a);
		aes_byte_t sq;
		aes_byte_t acc;
		sq = a;
		acc = 8'h01;
		for (int i = 1; i < 8; i++)
		begin
			sq = gf_mul(sq, sq);
			acc = gf_mul(acc, sq);
		end
		return acc;
	endfunction

	// Affine map, b xor four left rotations of b plus the constant
	function automatic aes_byte_t affine(input aes_byte_t b);
		return b ^ {b[6:0], b[7]} ^ {b[5:0], b[7:6]} ^ {b[4:0], b[7:5]}
			^ {b[3:0], b[7:4]} ^ `AES_SBOX_AFFINE;
	endfunction

	//////////////////////////////
	// Per byte S-box
	//////////////////////////////

	assign din_v = din;

	for (genvar i = 0; i < NBYTES; i++)
	begin : g_sbox
		assign dout_v[i*8 +: 8] = affine(gf_inv(din_v[i*8 +: 8]));
	end

	assign dout = dout_v;

endmodule

//--- src/aes_key_expand.sv
// On-the-fly AES-128 key schedule, loaded on ld and stepping one round key per clock
`include "aes_cfg.svh"

module aes_key_expand
	import aes_state_pkg::*;
	import aes_key_pkg::*;
(
	input  logic       clk,
	input  logic       ld,
	input  aes_key_t   key,
	output aes_state_t round_key
);

	// Cipher key split into its four words
	aes_state_t key_s;

	// Current round key words
	aes_col_t w0;
	aes_col_t w1;
	aes_col_t w2;
	aes_col_t w3;

	// Round constant of the next step
	aes_rcon_t rcon;

	// RotWord and SubWord of the last word
	aes_col_t rot_w;
	aes_col_t sub_w;

	// Next round key words
	aes_col_t t_w;
	aes_col_t w0_n;
	aes_col_t w1_n;
	aes_col_t w2_n;
	aes_col_t w3_n;

	assign key_s = key;

	//////////////////////////////
	// Word chain
	//////////////////////////////

	// Rotate one byte up
	assign rot_w = '{w3.r1, w3.r2, w3.r3, w3.r0};

	aes_sub_bytes #(.payload_t(aes_col_t)) u_subword (
		.din  (rot_w),
		.dout (sub_w)
	);

	always_comb
	begin
		// Rcon enters in the row 0 byte only
		t_w = sub_w ^ {rcon, 24'h000000};
		w0_n = w0 ^ t_w;
		w1_n = w1 ^ w0_n;
		w2_n = w2 ^ w1_n;
		w3_n = w3 ^ w2_n;
	end

	//////////////////////////////
	// Key and Rcon registers
	//////////////////////////////

	// ld restarts both the words and the Rcon sequence
	// Rcon doubles each round, 01 .. 80 then 1b, 36
	always_ff @(posedge clk)
	begin
		if (ld)
		begin
			w0 <= key_s.c0;
			w1 <= key_s.c1;
			w2 <= key_s.c2;
			w3 <= key_s.c3;
			rcon <= `AES_RCON_FIRST;
		end
		else
		begin
			w0 <= w0_n;
			w1 <= w1_n;
			w2 <= w2_n;
			w3 <= w3_n;
			rcon <= xtime(rcon);
		end
	end

	assign round_key = '{w0, w1, w2, w3};

endmodule

//--- src/aes_round_datapath.sv
// AES round datapath, one full round per clock plus the registered final round output
module aes_round_datapath
	import aes_state_pkg::*;
(
	input  logic       clk,
	input  logic       ld,
	input  logic       first_round,
	input  aes_state_t text_in,
	input  aes_state_t round_key,
	output aes_state_t text_out
);

	// Plaintext held from the ld cycle
	aes_state_t text_in_r;

	// Cipher state
	aes_state_t state;

	// Round stages
	aes_state_t sb_state;
	aes_state_t sr_state;
	aes_state_t mc_state;
	aes_state_t next_state;
	aes_state_t final_state;

	//////////////////////////////
	// Round functions
	//////////////////////////////

	// MixColumns on one column
	function automatic aes_col_t mix_col(input aes_col_t c);
		aes_col_t m;
		m.r0 = xtime(c.r0) ^ xtime(c.r1) ^ c.r1 ^ c.r2 ^ c.r3;
		m.r1 = c.r0 ^ xtime(c.r1) ^ xtime(c.r2) ^ c.r2 ^ c.r3;
		m.r2 = c.r0 ^ c.r1 ^ xtime(c.r2) ^ xtime(c.r3) ^ c.r3;
		m.r3 = xtime(c.r0) ^ c.r0 ^ c.r1 ^ c.r2 ^ xtime(c.r3);
		return m;
	endfunction

	aes_sub_bytes #(.payload_t(aes_state_t)) u_subbytes (
		.din  (state),
		.dout (sb_state)
	);

	// ShiftRows, row r takes its byte from column c + r
	assign sr_state.c0 = '{sb_state.c0.r0, sb_state.c1.r1, sb_state.c2.r2, sb_state.c3.r3};
	assign sr_state.c1 = '{sb_state.c1.r0, sb_state.c2.r1, sb_state.c3.r2, sb_state.c0.r3};
	assign sr_state.c2 = '{sb_state.c2.r0, sb_state.c3.r1, sb_state.c0.r2, sb_state.c1.r3};
	assign sr_state.c3 = '{sb_state.c3.r0, sb_state.c0.r1, sb_state.c1.r2, sb_state.c2.r3};

	assign mc_state.c0 = mix_col(sr_state.c0);
	assign mc_state.c1 = mix_col(sr_state.c1);
	assign mc_state.c2 = mix_col(sr_state.c2);
	assign mc_state.c3 = mix_col(sr_state.c3);

	// AddRoundKey for a normal and for the last round
	assign next_state = mc_state ^ round_key;
	assign final_state = sr_state ^ round_key;

	//////////////////////////////
	// Registers
	//////////////////////////////

	always_ff @(posedge clk)
	begin
		if (ld)
			text_in_r <= text_in;
	end

	// Initial AddRoundKey in the cycle after ld, a full round otherwise
	always_ff @(posedge clk)
	begin
		state <= first_round ? aes_state_t'(text_in_r ^ round_key) : next_state;
		// Valid only when done is high
		text_out <= final_state;
	end

endmodule

//--- src/aes_round_ctrl.sv
// AES round sequencing, counts the rounds after ld and raises done for one cycle
`include "aes_cfg.svh"

module aes_round_ctrl
	import aes_key_pkg::*;
(
	input  logic clk,
	input  logic rst,
	input  logic ld,
	output logic first_round,
	output logic done
);

	// Rounds left, zero when idle
	aes_round_cnt_t cnt;

	// ld delayed by one cycle
	logic ld_r;

	//////////////////////////////
	// Counter and strobes
	//////////////////////////////

	// Load with rounds plus one so the last count covers the output register
	// A new ld restarts the count at any time
	always_ff @(posedge clk)
	begin
		if (!rst)
		begin
			cnt <= '0;
			ld_r <= 1'b0;
			done <= 1'b0;
		end
		else
		begin
			ld_r <= ld;
			if (ld)
				cnt <= aes_round_cnt_t'(`AES_ROUNDS + 1);
			else if (cnt != '0)
				cnt <= cnt - 1'b1;
			// Last count reached, no restart pending
			done <= (cnt == aes_round_cnt_t'(1)) && !ld;
		end
	end

	assign first_round = ld_r;

endmodule

//--- src/aes_cipher_top.sv
// AES-128 encryption core top, pulse ld with key and text_in, read text_out while done is high
module aes_cipher_top
	import aes_state_pkg::*;
	import aes_key_pkg::*;
(
	input  logic       clk,
	input  logic       rst,
	input  logic       ld,
	input  aes_key_t   key,
	input  aes_state_t text_in,
	output logic       done,
	output aes_state_t text_out
);

	// Initial AddRoundKey select
	logic first_round;

	// Round key of the current cycle
	aes_state_t round_key;

	//////////////////////////////
	// Control
	//////////////////////////////

	aes_round_ctrl u_ctrl (
		.clk         (clk),
		.rst         (rst),
		.ld          (ld),
		.first_round (first_round),
		.done        (done)
	);

	//////////////////////////////
	// Key schedule and rounds
	//////////////////////////////

	aes_key_expand u_key (
		.clk       (clk),
		.ld        (ld),
		.key       (key),
		.round_key (round_key)
	);

	aes_round_datapath u_data (
		.clk         (clk),
		.ld          (ld),
		.first_round (first_round),
		.text_in     (text_in),
		.round_key   (round_key),
		.text_out    (text_out)
	);

endmodule

//--- sim/aes_properties.sv
// Concurrent checks on the round control strobes, bound into every aes_round_ctrl instance
`include "aes_cfg.svh"

module aes_properties
(
	input  logic clk,
	input  logic rst,
	input  logic ld,
	input  logic done
);
	timeunit 1ns;
	timeprecision 10ps;

	// ld history covers the ld edge and the eleven edges after it
	localparam int HIST = `AES_ROUNDS + 2;

	// Only the oldest edge carries ld
	localparam logic [HIST-1:0] LD_START = {1'b1, {(HIST-1){1'b0}}};

	// Bit 0 is the latest edge
	logic [HIST-1:0] ld_hist;

	always_ff @(posedge clk)
	begin
		if (!rst)
			ld_hist <= '0;
		else
			ld_hist <= {ld_hist[HIST-2:0], ld};
	end

	//////////////////////////////
	// Assertions
	//////////////////////////////

	// done is a single cycle pulse
	a_done_single : assert property (@(posedge clk) disable iff (!rst) done |=> !done)
		else $error("done stayed high for more than one cycle");

	// One ld, then eleven quiet edges
	a_done_latency : assert property (@(posedge clk) disable iff (!rst)
		done |-> (ld_hist == LD_START))
		else $error("done without a lone ld eleven edges before it");

endmodule

bind aes_round_ctrl aes_properties u_props (
	.clk  (clk),
	.rst  (rst),
	.ld   (ld),
	.done (done)
);

//--- sim/aes_checker.sv
// Testbench checker, models the done timing from ld, compares text_out and counts errors
`include "aes_cfg.svh"

module aes_checker
	import aes_state_pkg::*;
#(
	parameter int NAME_CHARS = 12
)
(
	input  logic                    clk,
	input  logic                    rst,
	input  logic                    ld,
	input  logic                    done,
	input  aes_state_t              text_out,
	input  aes_state_t              exp_ct,
	input  logic [NAME_CHARS*8-1:0] name,
	output int                      value_errs = 0,
	output int                      timing_errs = 0,
	output int                      results = 0
);
	timeunit 1ns;
	timeprecision 10ps;

	// Edges from the ld edge to the edge that raises done
	localparam int LATENCY = `AES_ROUNDS + 1;

	// Operation in flight
	logic armed = 1'b0;

	// Edges since the last ld edge
	int age = 0;

	// done expected in this cycle
	logic done_due;

	//////////////////////////////
	// Compare at the falling edge
	//////////////////////////////

	// Outputs and the next edge's inputs are both settled here
	always @(negedge clk)
	begin
		done_due = armed && (age == LATENCY);
		if (done !== done_due)
		begin
			timing_errs++;
			if (done_due)
				$display("done missing %0d edges after ld for %s", LATENCY, name);
			else
				$display("done is %b with no result due, %0d edges after ld", done, age);
		end
		else if (done_due)
		begin
			results++;
			if (text_out !== exp_ct)
			begin
				value_errs++;
				$display("Error %s: expected %h, actual %h", name, exp_ct, text_out);
			end
		end

		// Model the edge that follows
		if (!rst)
		begin
			armed = 1'b0;
			age = 0;
		end
		else if (ld === 1'b1)
		begin
			// Restart, any older operation is dropped
			armed = 1'b1;
			age = 0;
		end
		else if (armed)
		begin
			if (age < LATENCY)
				age++;
			else
				armed = 1'b0;
		end
	end

endmodule

//--- sim/aes_tb.sv
// Testbench top for the AES-128 core, runs the vector table and prints the final verdict
module aes_tb
	import aes_state_pkg::*;
	import aes_key_pkg::*;
();
	timeunit 1ns;
	timeprecision 10ps;

	//////////////////////////////
	// Vectors
	//////////////////////////////

	localparam int NAME_CHARS = 12;
	localparam int NROWS = 8;

	// Cycles allowed from ld to done
	localparam int DONE_LIMIT = 40;

	// FIPS-197 appendix B
	localparam aes_key_t KEY_B = 128'h2b7e1516_28aed2a6_abf71588_09cf4f3c;
	localparam aes_state_t PT_B = 128'h3243f6a8_885a308d_313198a2_e0370734;
	localparam aes_state_t CT_B = 128'h3925841d_02dc09fb_dc118597_196a0b32;

	// FIPS-197 appendix C.1
	localparam aes_key_t KEY_C = 128'h00010203_04050607_08090a0b_0c0d0e0f;
	localparam aes_state_t PT_C = 128'h00112233_44556677_8899aabb_ccddeeff;
	localparam aes_state_t CT_C = 128'h69c4e0d8_6a7b0430_d8cdb780_70b4c55a;

	// All zero key and block
	localparam aes_state_t CT_Z = 128'h66e94bd4_ef8a2c3b_884cfa59_ca342b2e;

	// restart starts the previous row first, chain means ld right after done
	typedef struct packed {
		logic [NAME_CHARS*8-1:0] name;
		aes_key_t                key;
		aes_state_t              pt;
		aes_state_t              ct;
		logic                    restart;
		logic                    chain;
	} vec_t;

	vec_t vectors [NROWS];

	// DUT ports
	logic       clk = 1'b0;
	logic       rst;
	logic       ld;
	aes_key_t   key;
	aes_state_t text_in;
	logic       done;
	aes_state_t text_out;

	// Row under test, seen by the checker
	logic [NAME_CHARS*8-1:0] cur_name;
	aes_state_t              exp_ct;

	// Error counts
	int value_errs;
	int timing_errs;
	int results;
	int timeouts;
	int count_errs;

	// Gap generator state
	logic [7:0] lfsr;

	aes_cipher_top u_dut (
		.clk      (clk),
		.rst      (rst),
		.ld       (ld),
		.key      (key),
		.text_in  (text_in),
		.done     (done),
		.text_out (text_out)
	);

	aes_checker #(.NAME_CHARS(NAME_CHARS)) u_chk (
		.clk         (clk),
		.rst         (rst),
		.ld          (ld),
		.done        (done),
		.text_out    (text_out),
		.exp_ct      (exp_ct),
		.name        (cur_name),
		.value_errs  (value_errs),
		.timing_errs (timing_errs),
		.results     (results)
	);

	// 4 ns clock
	initial
	begin
		forever #2 clk = ~clk;
	end

	//////////////////////////////
	// Helpers
	//////////////////////////////

	task automatic fill_table();
		vectors[0] = '{"fips_app_b_1", KEY_B, PT_B, CT_B, 1'b0, 1'b0};
		vectors[1] = '{"fips_app_c_1", KEY_C, PT_C, CT_C, 1'b0, 1'b0};
		vectors[2] = '{"all_zero_blk", '0, '0, CT_Z, 1'b0, 1'b0};
		vectors[3] = '{"restart_to_c", KEY_C, PT_C, CT_C, 1'b1, 1'b0};
		vectors[4] = '{"repeat_app_b", KEY_B, PT_B, CT_B, 1'b0, 1'b1};
		vectors[5] = '{"restart_to_z", '0, '0, CT_Z, 1'b1, 1'b0};
		vectors[6] = '{"repeat_app_c", KEY_C, PT_C, CT_C, 1'b0, 1'b1};
		vectors[7] = '{"repeat_zeros", '0, '0, CT_Z, 1'b0, 1'b1};
	endtask

	// One edge, inputs move 1 ns later
	task automatic step();
		@(posedge clk);
		#1;
	endtask

	// Galois LFSR, x^8 + x^6 + x^5 + x^4 + 1
	function automatic logic [7:0] lfsr_next(input logic [7:0] s);
		return s[0] ? ((s >> 1) ^ 8'hb8) : (s >> 1);
	endfunction

	// Low bit out, one step per bit
	task automatic take_bits(input int n, output int value);
		value = 0;
		for (int b = 0; b < n; b++)
		begin
			value = (value << 1) | int'(lfsr[0]);
			lfsr = lfsr_next(lfsr);
		end
	endtask

	// One cycle ld, then junk on key and text_in
	task automatic start_block(input aes_key_t k, input aes_state_t p);
		ld = 1'b1;
		key = k;
		text_in = p;
		step();
		ld = 1'b0;
		key = ~k;
		text_in = aes_state_t'(~p);
	endtask

	task automatic wait_done();
		int n;
		logic seen;
		n = 0;
		seen = 1'b0;
		while (!seen && n < DONE_LIMIT)
		begin
			@(negedge clk);
			seen = (done === 1'b1);
			n++;
		end
		if (!seen)
		begin
			timeouts++;
			$display("Timeout: no done within %0d cycles of ld for %s", DONE_LIMIT, cur_name);
		end
	endtask

	//////////////////////////////
	// Stimulus
	//////////////////////////////

	initial
	begin
		int gap;
		int prev;
		ld = 1'b0;
		key = '0;
		text_in = '0;
		rst = 1'b0;
		cur_name = '0;
		exp_ct = '0;
		timeouts = 0;
		count_errs = 0;
		lfsr = 8'd85;
		fill_table();

		// Reset for three edges
		repeat (3) @(posedge clk);
		#1;
		rst = 1'b1;

		// Idle, done must stay low
		repeat (4) step();

		for (int i = 0; i < NROWS; i++)
		begin
			if (vectors[i].chain)
				gap = 0;
			else
				take_bits(3, gap);
			repeat (gap) step();
			cur_name = vectors[i].name;
			exp_ct = vectors[i].ct;
			if (vectors[i].restart)
			begin
				prev = (i == 0) ? 0 : i - 1;
				// Earlier row, overtaken five edges later
				start_block(vectors[prev].key, vectors[prev].pt);
				repeat (4) step();
			end
			start_block(vectors[i].key, vectors[i].pt);
			wait_done();
			step();
		end

		// Trailing idle, no stray done
		repeat (16) step();

		if (results != NROWS)
		begin
			count_errs++;
			$display("Wrong number of results, saw %0d, expected %0d", results, NROWS);
		end
		$display("Checked %0d results: %0d value, %0d timing, %0d timeout, %0d count errors",
			results, value_errs, timing_errs, timeouts, count_errs);
		if (value_errs + timing_errs + timeouts + count_errs == 0)
			$display("No errors");
		else
			$display("Errors found");
		$finish;
	end

endmodule

//--- all.f
+incdir+src
src/aes_state_pkg.sv
src/aes_key_pkg.sv
src/aes_sub_bytes.sv
src/aes_key_expand.sv
src/aes_round_datapath.sv
src/aes_round_ctrl.sv
src/aes_cipher_top.sv
sim/aes_properties.sv
sim/aes_checker.sv
sim/aes_tb.sv

//--- Makefile
# Verilator build and run of the AES-128 testbench

TOP := aes_tb

.PHONY: compile run clean

# Build the simulation binary from the file list
compile:
	verilator --binary --timing --assert --timescale 1ns/10ps \
		--top-module $(TOP) -f all.f -Mdir obj_dir

# Pass only when the pass line shows up in the output
run: compile
	./obj_dir/V$(TOP) | tee /dev/stderr | grep -qx "No errors"

clean:
	rm -rf obj_dir
